//--- verilog/video_pkg.sv
/*
 * Raster timing constants and pixel/colour types shared by the video blocks.
 * Timing, layers and mixer refer to these by scoped name.
 */

package video_pkg;

    // Raster geometry, one pixel per clock
    localparam logic [8:0] h_total   = 9'd384;
    localparam logic [8:0] h_visible = 9'd320;
    localparam logic [8:0] v_total   = 9'd262;
    localparam logic [8:0] v_visible = 9'd224;

    // Lines that pull the line interrupt low
    localparam logic [8:0] line_irq_a = 9'd64;
    localparam logic [8:0] line_irq_b = 9'd128;
    localparam logic [8:0] line_irq_c = 9'd192;

    // Palette index shown where no layer is opaque
    localparam logic [3:0] back_color = 4'd0;

    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
    } coord_t;

    // One layer's pixel, palette index plus a visibility flag
    typedef struct packed {
        logic       opaque;
        logic [3:0] color;
    } layer_pxl_t;

    // 5:5:5 output colour, also the palette entry format
    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    typedef enum logic [1:0] {
        sel_back,
        sel_road,
        sel_obj
    } layer_sel_e;

endpackage

//--- verilog/cpu_pkg.sv
/*
 * CPU write bus and register map decode enums.
 * Each video block decodes its own region from the broadcast write.
 */

package cpu_pkg;

    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [15:0] data;
    } cpu_wr_t;

    // Region from addr[7:6]
    typedef enum logic [1:0] {
        rg_pal  = 2'd0,
        rg_obj  = 2'd1,
        rg_road = 2'd2
    } region_e;

    // Sprite field from addr[1:0], sprite number in addr[3:2]
    typedef enum logic [1:0] {
        of_x, of_y, of_color, of_enable
    } obj_field_e;

    // Road field from addr[1:0]
    typedef enum logic [1:0] {
        rf_center, rf_half_width, rf_stripe_shift, rf_colors
    } road_field_e;

endpackage

//--- verilog/video_timing.sv
/*
 * Raster generator: pixel and line counters, visible area flag,
 * vertical interrupt pulse and the registered line interrupt.
 */
`timescale 1ns/1ps

module video_timing (
    input  logic              clk,
    input  logic              rst,
    output video_pkg::coord_t pos,
    output logic              vis,
    output logic              vint,
    output logic              line_intn
);

    logic [8:0] h_cnt;
    logic [8:0] v_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= 9'd0;
            v_cnt <= 9'd0;
        end else if (h_cnt == video_pkg::h_total - 9'd1) begin
            h_cnt <= 9'd0;
            if (v_cnt == video_pkg::v_total - 9'd1) begin
                v_cnt <= 9'd0;
            end else begin
                v_cnt <= v_cnt + 9'd1;
            end
        end else begin
            h_cnt <= h_cnt + 9'd1;
        end
    end

    assign pos  = '{h: h_cnt, v: v_cnt};
    assign vis  = (h_cnt < video_pkg::h_visible) && (v_cnt < video_pkg::v_visible);

    // First pixel of vertical blanking
    assign vint = (h_cnt == 9'd0) && (v_cnt == video_pkg::v_visible);

    // Low for the whole of each interrupt line, one cycle late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_intn <= 1'b1;
        end else begin
            line_intn <= !(v_cnt == video_pkg::line_irq_a ||
                           v_cnt == video_pkg::line_irq_b ||
                           v_cnt == video_pkg::line_irq_c);
        end
    end

    a_vint_single: assert property (
        @(posedge clk) disable iff (rst) vint |=> !vint
    );

endmodule

//--- verilog/road_layer.sv
/*
 * Road layer: a centred band with a 4 pixel kerb on each edge and
 * road/stripe colour alternating on the selected line bit.
 */
`timescale 1ns/1ps

module road_layer (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_pkg::cpu_wr_t      cpu_wr,
    input  video_pkg::coord_t     pos,
    output video_pkg::layer_pxl_t road_pxl
);

    logic [8:0] center;
    logic [8:0] half_width;
    logic [2:0] stripe_shift;
    logic [3:0] road_col;
    logic [3:0] kerb_col;
    logic [3:0] stripe_col;

    logic       road_wr;
    logic [8:0] d;
    logic [9:0] d_pad;
    logic       in_band;
    logic       in_kerb;
    logic       in_inner;

    assign road_wr = cpu_wr.we &&
        (cpu_pkg::region_e'(cpu_wr.addr[7:6]) == cpu_pkg::rg_road);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            center       <= 9'd0;
            half_width   <= 9'd0;
            stripe_shift <= 3'd0;
            road_col     <= 4'd0;
            kerb_col     <= 4'd0;
            stripe_col   <= 4'd0;
        end else if (road_wr) begin
            case (cpu_pkg::road_field_e'(cpu_wr.addr[1:0]))
                cpu_pkg::rf_center:       center       <= cpu_wr.data[8:0];
                cpu_pkg::rf_half_width:   half_width   <= cpu_wr.data[8:0];
                cpu_pkg::rf_stripe_shift: stripe_shift <= cpu_wr.data[2:0];
                cpu_pkg::rf_colors: begin
                    road_col   <= cpu_wr.data[3:0];
                    kerb_col   <= cpu_wr.data[7:4];
                    stripe_col <= cpu_wr.data[11:8];
                end
                default: ;
            endcase
        end
    end

    // Distance from the centre line; the +4 avoids underflow on narrow roads
    always_comb begin
        d        = (pos.h >= center) ? pos.h - center : center - pos.h;
        d_pad    = {1'b0, d} + 10'd4;
        in_band  = (half_width != 9'd0) && (d <= half_width);
        in_kerb  = in_band && (d_pad > {1'b0, half_width});
        in_inner = in_band && !in_kerb;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            road_pxl <= '0;
        end else if (in_kerb) begin
            road_pxl <= '{opaque: 1'b1, color: kerb_col};
        end else if (in_inner) begin
            road_pxl <= '{opaque: 1'b1,
                          color: pos.v[stripe_shift] ? stripe_col : road_col};
        end else begin
            road_pxl <= '0;
        end
    end

endmodule

//--- verilog/obj_layer.sv
/*
 * Object layer: four solid 16x16 sprites from a CPU-written table.
 * Lower sprite numbers are drawn in front.
 */
`timescale 1ns/1ps

module obj_layer (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_pkg::cpu_wr_t      cpu_wr,
    input  video_pkg::coord_t     pos,
    output video_pkg::layer_pxl_t obj_pxl
);

    logic [8:0] x     [4];
    logic [8:0] y     [4];
    logic [3:0] color [4];
    logic [3:0] en;

    logic       obj_wr;
    logic [1:0] wr_idx;
    logic [3:0] hit;
    logic [1:0] win_idx;
    logic       any_hit;

    assign obj_wr = cpu_wr.we &&
        (cpu_pkg::region_e'(cpu_wr.addr[7:6]) == cpu_pkg::rg_obj);
    assign wr_idx = cpu_wr.addr[3:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                x[i]     <= 9'd0;
                y[i]     <= 9'd0;
                color[i] <= 4'd0;
            end
            en <= 4'd0;
        end else if (obj_wr) begin
            case (cpu_pkg::obj_field_e'(cpu_wr.addr[1:0]))
                cpu_pkg::of_x:      x[wr_idx]     <= cpu_wr.data[8:0];
                cpu_pkg::of_y:      y[wr_idx]     <= cpu_wr.data[8:0];
                cpu_pkg::of_color:  color[wr_idx] <= cpu_wr.data[3:0];
                cpu_pkg::of_enable: en[wr_idx]    <= cpu_wr.data[0];
                default: ;
            endcase
        end
    end

    // Box test in 10 bits so x+15 does not wrap
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hit[i] = en[i] &&
                ({1'b0, pos.h} >= {1'b0, x[i]}) &&
                ({1'b0, pos.h} <= {1'b0, x[i]} + 10'd15) &&
                ({1'b0, pos.v} >= {1'b0, y[i]}) &&
                ({1'b0, pos.v} <= {1'b0, y[i]} + 10'd15);
        end
    end

    // Scan downwards so the lowest hit is left last
    always_comb begin
        win_idx = 2'd0;
        any_hit = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (hit[i]) begin
                win_idx = 2'(i);
                any_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_pxl <= '0;
        end else begin
            obj_pxl <= '{opaque: any_hit, color: any_hit ? color[win_idx] : 4'd0};
        end
    end

    // An opaque pixel came from a sprite that was enabled when it was picked
    a_obj_enabled: assert property (
        @(posedge clk) disable iff (rst) obj_pxl.opaque |-> $past(en[win_idx])
    );

endmodule

//--- verilog/colmix.sv
/*
 * Colour mixer: layer priority, 16-entry palette and blanking.
 * Position and visible flag are delayed so they leave together with rgb.
 */
`timescale 1ns/1ps

module colmix (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_pkg::cpu_wr_t      cpu_wr,
    input  video_pkg::coord_t     pos,
    input  logic                  vis,
    input  video_pkg::layer_pxl_t road_pxl,
    input  video_pkg::layer_pxl_t obj_pxl,
    output video_pkg::rgb_t       rgb,
    output video_pkg::coord_t     out_pos,
    output logic                  out_vis
);

    video_pkg::rgb_t       pal [16];
    video_pkg::coord_t     pos_q;
    logic                  vis_q;
    video_pkg::layer_sel_e sel;
    logic [3:0]            pal_idx;
    logic                  pal_wr;

    assign pal_wr = cpu_wr.we &&
        (cpu_pkg::region_e'(cpu_wr.addr[7:6]) == cpu_pkg::rg_pal);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_wr) begin
            pal[cpu_wr.addr[3:0]] <= cpu_wr.data[14:0];
        end
    end

    // Objects over road over background
    always_comb begin
        if (obj_pxl.opaque) begin
            sel = video_pkg::sel_obj;
        end else if (road_pxl.opaque) begin
            sel = video_pkg::sel_road;
        end else begin
            sel = video_pkg::sel_back;
        end
        case (sel)
            video_pkg::sel_obj:  pal_idx = obj_pxl.color;
            video_pkg::sel_road: pal_idx = road_pxl.color;
            default:             pal_idx = video_pkg::back_color;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_q   <= '0;
            vis_q   <= 1'b0;
            rgb     <= '0;
            out_pos <= '0;
            out_vis <= 1'b0;
        end else begin
            // Stage 1 lines up with the layer pixels
            pos_q   <= pos;
            vis_q   <= vis;
            // Stage 2 palette lookup
            rgb     <= vis_q ? pal[pal_idx] : '0;
            out_pos <= pos_q;
            out_vis <= vis_q;
        end
    end

    a_blank_black: assert property (
        @(posedge clk) disable iff (rst) !out_vis |-> (rgb == '0)
    );

endmodule

//--- verilog/video_top.sv
/*
 * Video subsystem top: raster timing, road and object layers, colour mixer.
 * CPU writes are broadcast and each block decodes its own region.
 */
`timescale 1ns/1ps

module video_top (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::cpu_wr_t  cpu_wr,
    output video_pkg::rgb_t   rgb,
    output video_pkg::coord_t out_pos,
    output logic              out_vis,
    output logic              vint,
    output logic              line_intn
);

    video_pkg::coord_t     pos;
    logic                  vis;
    video_pkg::layer_pxl_t road_pxl;
    video_pkg::layer_pxl_t obj_pxl;

    video_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pos       ( pos       ),
        .vis       ( vis       ),
        .vint      ( vint      ),
        .line_intn ( line_intn )
    );

    road_layer u_road (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_wr   ( cpu_wr   ),
        .pos      ( pos      ),
        .road_pxl ( road_pxl )
    );

    obj_layer u_obj (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .cpu_wr  ( cpu_wr  ),
        .pos     ( pos     ),
        .obj_pxl ( obj_pxl )
    );

    colmix u_colmix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_wr   ( cpu_wr   ),
        .pos      ( pos      ),
        .vis      ( vis      ),
        .road_pxl ( road_pxl ),
        .obj_pxl  ( obj_pxl  ),
        .rgb      ( rgb      ),
        .out_pos  ( out_pos  ),
        .out_vis  ( out_vis  )
    );

endmodule

//--- tb/tb_video_top.sv
/*
 * Testbench for video_top. CPU writes and expected results come from
 * tb/video_stimulus.txt and are checked against rgb, out_vis, line_intn and vint.
 */
`timescale 1ns/1ps

module tb_video_top;

    localparam int frame_cycles = int'(video_pkg::h_total) * int'(video_pkg::v_total);
    localparam int pos_timeout  = 2 * frame_cycles;

    logic              clk;
    logic              rst;
    cpu_pkg::cpu_wr_t  cpu_wr;
    video_pkg::rgb_t   rgb;
    video_pkg::coord_t out_pos;
    logic              out_vis;
    logic              vint;
    logic              line_intn;

    integer seed = 32'h4473_be24;
    int     n_tests;
    int     n_errors;

    video_top UUT (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cpu_wr    ( cpu_wr    ),
        .rgb       ( rgb       ),
        .out_pos   ( out_pos   ),
        .out_vis   ( out_vis   ),
        .vint      ( vint      ),
        .line_intn ( line_intn )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_rgb(input string name, input video_pkg::rgb_t exp,
                             input video_pkg::rgb_t act);
        n_tests++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok %s rgb %h", name, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_tests++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end else begin
            $display("ok %s value %b", name, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        n_tests++;
        if (act != exp) begin
            n_errors++;
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
        end else begin
            $display("ok %s count %0d", name, act);
        end
    endtask

    // One write cycle, then let it pass both pipeline stages
    task automatic cpu_write(input logic [7:0] addr, input logic [15:0] data);
        @(posedge clk);
        cpu_wr <= '{we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        cpu_wr <= '0;
        repeat (2) @(posedge clk);
    endtask

    // Sampled on the falling edge, away from register updates
    task automatic wait_for_pos(input int h, input int v, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < pos_timeout) begin
            @(negedge clk);
            cycles++;
            if (out_pos.h == 9'(h) && out_pos.v == 9'(v)) begin
                found = 1'b1;
            end
        end
    endtask

    task automatic report_timeout(input string name, input int h, input int v);
        n_tests++;
        n_errors++;
        $display("%s: output position (%0d, %0d) did not appear within two frames",
                 name, h, v);
    endtask

    // Any window of one full frame holds exactly one vint
    task automatic count_vint(output int pulses);
        pulses = 0;
        repeat (frame_cycles) begin
            @(negedge clk);
            if (vint) begin
                pulses++;
            end
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          got;
        string       cmd;
        string       name;
        string       rest;
        logic [7:0]  addr;
        logic [15:0] data;
        int          h;
        int          v;
        logic [14:0] exp_rgb;
        logic        exp_bit;
        logic        exp_vis;
        int          exp_cnt;
        int          pulses;
        bit          found;

        rst      = 1'b1;
        cpu_wr   = '0;
        n_tests  = 0;
        n_errors = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("tb/video_stimulus.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("could not open the stimulus file tb/video_stimulus.txt");
        end else begin
            code = $fscanf(fd, "%s", cmd);
            while (code == 1) begin
                if (cmd == "W") begin
                    got = $fscanf(fd, "%h %h", addr, data);
                    if (got != 2) begin
                        n_errors++;
                        $display("bad write line in the stimulus file");
                        break;
                    end
                    cpu_write(addr, data);
                end else if (cmd == "C") begin
                    got = $fscanf(fd, "%s %d %d %h", name, h, v, exp_rgb);
                    if (got != 4) begin
                        n_errors++;
                        $display("bad colour check line in the stimulus file");
                        break;
                    end
                    // Visible area is h below 320 and v below 224
                    exp_vis = (h < int'(video_pkg::h_visible)) &&
                              (v < int'(video_pkg::v_visible));
                    wait_for_pos(h, v, found);
                    if (found) begin
                        check_rgb(name, video_pkg::rgb_t'(exp_rgb), rgb);
                        check_bit({name, "_vis"}, exp_vis, out_vis);
                    end else begin
                        report_timeout(name, h, v);
                    end
                end else if (cmd == "L") begin
                    got = $fscanf(fd, "%s %d %b", name, v, exp_bit);
                    if (got != 3) begin
                        n_errors++;
                        $display("bad interrupt check line in the stimulus file");
                        break;
                    end
                    wait_for_pos(5, v, found);
                    if (found) begin
                        check_bit(name, exp_bit, line_intn);
                    end else begin
                        report_timeout(name, 5, v);
                    end
                end else if (cmd == "V") begin
                    got = $fscanf(fd, "%s %d", name, exp_cnt);
                    if (got != 2) begin
                        n_errors++;
                        $display("bad vint check line in the stimulus file");
                        break;
                    end
                    count_vint(pulses);
                    check_count(name, exp_cnt, pulses);
                end else if (cmd.getc(0) == "#") begin
                    got = $fgets(rest, fd);
                end else begin
                    n_errors++;
                    $display("unknown command %s in the stimulus file", cmd);
                    break;
                end
                code = $fscanf(fd, "%s", cmd);
            end
            $fclose(fd);
        end

        if (n_tests == 0) begin
            n_errors++;
            $display("no checks were run");
        end
        $display("summary: %0d checks, %0d errors", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb/video_stimulus.txt
# W addr data (hex) | C name h v rgb (h v decimal, rgb hex)
# L name v line_intn | V name vint pulses over one frame
C reset_bg 10 10 0000
W 00 7c00
C bg_red 10 10 7c00
# Palette: road, kerb, stripe, sprite 1, sprite 2
W 01 1084
W 02 7fff
W 03 03e0
W 04 001f
W 05 7c1f
# Road: center 160, half width 40, stripe on v bit 3, colours 3/2/1
W 80 00a0
W 81 0028
W 82 0003
W 83 0321
C road_center 160 20 1084
C road_stripe 160 40 03e0
C road_inner_edge 196 20 1084
C kerb_left 122 20 7fff
C kerb_right 200 20 7fff
C outside_right 201 20 7c00
C outside_left 119 20 7c00
# Sprite 1 at (150,100) colour 4, sprite 2 at (158,108) colour 5
W 44 0096
W 45 0064
W 46 0004
W 47 0001
W 48 009e
W 49 006c
W 4a 0005
W 4b 0001
C spr1_over_road 152 102 001f
C spr1_right_edge 165 101 001f
C past_spr1_edge 166 101 1084
C spr2_only 170 120 7c1f
C overlap_spr1_wins 160 110 001f
W 47 0000
C spr1_off_road 152 102 1084
C overlap_spr2_left 160 110 7c1f
C hblank 330 20 0000
C vblank 10 230 0000
C vblank_road 160 230 0000
L irq_line_64 64 0
L irq_line_128 128 0
L irq_line_192 192 0
L no_irq_63 63 1
L no_irq_100 100 1
V vint_one_frame 1

//--- sim.f
verilog/video_pkg.sv
verilog/cpu_pkg.sv
verilog/video_timing.sv
verilog/road_layer.sv
verilog/obj_layer.sv
verilog/colmix.sv
verilog/video_top.sv
tb/tb_video_top.sv

//--- Bender.yml
package:
  name: video_subsystem

sources:
  - verilog/video_pkg.sv
  - verilog/cpu_pkg.sv
  - verilog/video_timing.sv
  - verilog/road_layer.sv
  - verilog/obj_layer.sv
  - verilog/colmix.sv
  - verilog/video_top.sv
  - target: test
    files:
      - tb/tb_video_top.sv
